// File: project.f
+incdir+verif
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_reg_file.sv
rtl/rv_decode_stage.sv
rtl/rv_execute_stage.sv
rtl/rv_writeback_stage.sv
rtl/rv_exec_core.sv
verif/tb_rv_exec_core.sv

// File: Bender.yml
package:
  name: rv_exec_core

sources:
  - files:
      - rtl/rv_pkg.sv
      - rtl/rv_alu.sv
      - rtl/rv_reg_file.sv
      - rtl/rv_decode_stage.sv
      - rtl/rv_execute_stage.sv
      - rtl/rv_writeback_stage.sv
      - rtl/rv_exec_core.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_rv_exec_core.sv

// File: verif/rv_test_table.svh
// instruction table for the execution unit testbench
// columns: instruction word, result expected, expected rd, expected value

localparam int TABLE_LEN = 28;

localparam test_entry_t test_table [TABLE_LEN] = '{
  {32'h06400093, 1'b1, 5'd1,  32'h00000064}, // addi x1, x0, 100
  {32'hFFD00113, 1'b1, 5'd2,  32'hFFFFFFFD}, // addi x2, x0, -3
  {32'h00500193, 1'b1, 5'd3,  32'h00000005}, // addi x3, x0, 5
  {32'h00208233, 1'b1, 5'd4,  32'h00000061}, // add  x4, x1, x2
  {32'h403082B3, 1'b1, 5'd5,  32'h0000005F}, // sub  x5, x1, x3
  {32'h00309333, 1'b1, 5'd6,  32'h00000C80}, // sll  x6, x1, x3
  {32'h0020C3B3, 1'b1, 5'd7,  32'hFFFFFF99}, // xor  x7, x1, x2
  {32'h00315433, 1'b1, 5'd8,  32'h07FFFFFF}, // srl  x8, x2, x3
  {32'h0030E4B3, 1'b1, 5'd9,  32'h00000065}, // or   x9, x1, x3
  {32'h0043F533, 1'b1, 5'd10, 32'h00000001}, // and  x10, x7, x4
  {32'hFFF0C593, 1'b1, 5'd11, 32'hFFFFFF9B}, // xori x11, x1, -1
  {32'h80006613, 1'b1, 5'd12, 32'hFFFFF800}, // ori  x12, x0, -2048
  {32'h0F03F693, 1'b1, 5'd13, 32'h00000090}, // andi x13, x7, 0xf0
  {32'h01B09713, 1'b1, 5'd14, 32'h20000000}, // slli x14, x1, 27
  {32'h01C15793, 1'b1, 5'd15, 32'h0000000F}, // srli x15, x2, 28
  {32'hF3808813, 1'b1, 5'd16, 32'hFFFFFF9C}, // addi x16, x1, -200
  {32'h00700893, 1'b1, 5'd17, 32'h00000007}, // addi x17, x0, 7
  {32'h00188893, 1'b1, 5'd17, 32'h00000008}, // addi x17, x17, 1  distance 1
  {32'h01188933, 1'b1, 5'd18, 32'h00000010}, // add  x18, x17, x17  newest x17 wins
  {32'h412889B3, 1'b1, 5'd19, 32'hFFFFFFF8}, // sub  x19, x17, x18  distance 2 and 1
  {32'h0000A083, 1'b0, 5'd0,  32'h00000000}, // lw   x1, 0(x1)  dropped
  {32'h021080B3, 1'b0, 5'd0,  32'h00000000}, // mul  x1, x1, x1  dropped
  {32'h0020A0B3, 1'b0, 5'd0,  32'h00000000}, // slt  x1, x1, x2  dropped
  {32'h4030D093, 1'b0, 5'd0,  32'h00000000}, // srai x1, x1, 3  dropped
  {32'h00008A13, 1'b1, 5'd20, 32'h00000064}, // addi x20, x1, 0  x1 untouched
  {32'h00508013, 1'b1, 5'd0,  32'h00000069}, // addi x0, x1, 5  still reported
  {32'h00100AB3, 1'b1, 5'd21, 32'h00000064}, // add  x21, x0, x1  x0 reads zero
  {32'h00300B13, 1'b1, 5'd22, 32'h00000003}  // addi x22, x0, 3
};

// File: verif/tb_rv_exec_core.sv
// testbench for the RV32I execution unit
// runs the instruction table twice, with out_ready held high and then with random output stalls

`timescale 1ns/100ps

module tb_rv_exec_core;

  typedef struct packed {
    logic [31:0] inst;
    logic        has_out;  // supported op, one result expected
    logic [4:0]  rd;
    logic [31:0] value;
  } test_entry_t;

  `include "rv_test_table.svh"

  localparam int MAX_CYCLES = 2 * (TABLE_LEN * 8 + 50); // two passes
  localparam int LATENCY    = 3;  // input edge to output edge, no stalls

  logic            clk;
  logic            reset;
  logic            in_valid;
  logic            in_ready;
  rv_pkg::word_t   in_inst;
  logic            out_valid;
  logic            out_ready;
  rv_pkg::result_t out_result;

  int          cycle_count = 0;
  int          checks      = 0;
  int          errors      = 0;
  int          accept_cycles [$];
  int unsigned seed_val;

  rv_exec_core dut0 (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_inst    (in_inst),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  endtask

  // one word per handshake, held while in_ready is low
  task automatic drive_table();
    for (int i = 0; i < TABLE_LEN; i++) begin
      @(negedge clk);
      in_valid = 1'b1;
      in_inst  = test_table[i].inst;
      @(posedge clk);
      while (!in_ready) begin
        @(posedge clk);
      end
      if (test_table[i].has_out) begin
        accept_cycles.push_back(cycle_count);
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    in_inst  = '0;
  endtask

  task automatic collect_results(input int pass_no, input bit stall_out);
    int              idx;
    int              n_got;
    int              n_expected;
    int              accepted_at;
    int              errors_before;
    bit              stalled;
    rv_pkg::result_t held;
    idx        = 0;
    n_got      = 0;
    n_expected = 0;
    stalled    = 1'b0;
    for (int i = 0; i < TABLE_LEN; i++) begin
      n_expected += test_table[i].has_out;
    end
    while (n_got < n_expected) begin
      @(negedge clk);
      out_ready = stall_out ? (($urandom % 4) != 0) : 1'b1;
      @(posedge clk);
      if (stalled) begin  // previous edge was a stall
        check("valid dropped while stalled", out_valid, 1'b1);
        check("output changed while stalled", out_result, held);
      end
      if (out_valid && !out_ready) begin  // back-pressure freezes the input side
        check("in_ready high during output stall", in_ready, 1'b0);
      end
      if (!stall_out) begin
        check("in_ready low with out_ready high", in_ready, 1'b1);
      end
      stalled = out_valid && !out_ready;
      held    = out_result;
      if (out_valid && out_ready) begin
        while (!test_table[idx].has_out) idx++;
        errors_before = errors;
        accepted_at   = accept_cycles.pop_front();
        check($sformatf("entry %0d rd", idx), out_result.rd, test_table[idx].rd);
        check($sformatf("entry %0d value", idx), out_result.value, test_table[idx].value);
        if (!stall_out) begin
          check($sformatf("entry %0d latency", idx), cycle_count - accepted_at, LATENCY);
        end
        $display("pass %0d, entry %0d: x%0d = %h %s", pass_no, idx, out_result.rd,
                 out_result.value, (errors == errors_before) ? "ok" : "wrong");
        idx++;
        n_got++;
      end
    end
    // pipe should now stay empty
    @(negedge clk);
    out_ready = 1'b1;
    repeat (6) begin
      @(posedge clk);
      check($sformatf("pass %0d extra output x%0d after the last result", pass_no,
                      out_result.rd), out_valid, 1'b0);
    end
  endtask

  initial begin
    seed_val  = $urandom(17092);
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_inst   = '0;
    out_ready = 1'b1;
    for (int pass_no = 1; pass_no <= 2; pass_no++) begin
      apply_reset();
      check("in_ready after reset", in_ready, 1'b1);
      check("out_valid after reset", out_valid, 1'b0);
      accept_cycles.delete();
      fork
        drive_table();
        collect_results(pass_no, pass_no == 2);
      join
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    wait (cycle_count >= MAX_CYCLES);
    $display("Timeout after %0d cycles, results are missing", cycle_count);
    $display("Errors found");
    $finish;
  end

endmodule

// File: rtl/rv_exec_core.sv
// top of the three-step RV32I integer execution unit
// instruction words in on valid/ready, rd/value results out on valid/ready

`timescale 1ns/100ps

module rv_exec_core (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  output logic             in_ready,
  input  rv_pkg::word_t    in_inst,
  output logic             out_valid,
  input  logic             out_ready,
  output rv_pkg::result_t  out_result
);

  logic              advance;
  logic              dec_valid;
  rv_pkg::decoded_t  dec;
  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::reg_addr_t rs2_addr;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  logic              ex_valid;
  rv_pkg::result_t   ex_result;
  logic              wr_en;
  rv_pkg::reg_addr_t wr_addr;
  rv_pkg::word_t     wr_data;

  rv_decode_stage decode0 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_inst   (in_inst),
    .advance   (advance),
    .in_ready  (in_ready),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  rv_reg_file rf0 (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute_stage execute0 (
    .clk       (clk),
    .reset     (reset),
    .advance   (advance),
    .dec_valid (dec_valid),
    .dec       (dec),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .wb_valid  (out_valid),   // held output item doubles as the far forward source
    .wb_result (out_result),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .ex_valid  (ex_valid),
    .ex_result (ex_result)
  );

  rv_writeback_stage writeback0 (
    .clk        (clk),
    .reset      (reset),
    .ex_valid   (ex_valid),
    .ex_result  (ex_result),
    .out_ready  (out_ready),
    .advance    (advance),
    .out_valid  (out_valid),
    .out_result (out_result),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data)
  );

endmodule

// File: rtl/rv_writeback_stage.sv
// output side: holds the result item for the valid/ready handshake
// drives the pipeline advance and writes the regfile on hand-off

`timescale 1ns/100ps

module rv_writeback_stage (
  input  logic               clk,
  input  logic               reset,
  input  logic               ex_valid,
  input  rv_pkg::result_t    ex_result,
  input  logic               out_ready,
  output logic               advance,
  output logic               out_valid,
  output rv_pkg::result_t    out_result,
  output logic               wr_en,
  output rv_pkg::reg_addr_t  wr_addr,
  output rv_pkg::word_t      wr_data
);

  // empty or draining this cycle
  assign advance = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      out_result <= ex_result;
    end
  end

  // commit to the regfile on the same edge as the output transfer
  assign wr_en   = out_valid && out_ready;
  assign wr_addr = out_result.rd;
  assign wr_data = out_result.value;

  a_hold_stalled: assert property (
    @(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_result))
  ) else $error("out_result changed while stalled");

endmodule

// File: rtl/rv_execute_stage.sv
// execute step: operand forwarding, immediate select and ALU
// result is registered with its rd on advance

`timescale 1ns/100ps

module rv_execute_stage (
  input  logic               clk,
  input  logic               reset,
  input  logic               advance,
  input  logic               dec_valid,
  input  rv_pkg::decoded_t   dec,
  input  rv_pkg::word_t      rs1_data,
  input  rv_pkg::word_t      rs2_data,
  input  logic               wb_valid,
  input  rv_pkg::result_t    wb_result,
  output rv_pkg::reg_addr_t  rs1_addr,
  output rv_pkg::reg_addr_t  rs2_addr,
  output logic               ex_valid,
  output rv_pkg::result_t    ex_result
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_y;

  // newest producer first: own result reg, then writeback, then regfile
  function automatic rv_pkg::word_t fwd_operand(
    input rv_pkg::reg_addr_t src,
    input rv_pkg::word_t     rf_data,
    input logic              near_valid,
    input rv_pkg::result_t   near,
    input logic              far_valid,
    input rv_pkg::result_t   far
  );
    if (src == '0) return '0;
    if (near_valid && near.rd == src) return near.value;
    if (far_valid && far.rd == src) return far.value;
    return rf_data;
  endfunction

  assign rs1_addr = dec.rs1;
  assign rs2_addr = dec.rs2;

  assign op_a  = fwd_operand(dec.rs1, rs1_data, ex_valid, ex_result, wb_valid, wb_result);
  assign op_b  = fwd_operand(dec.rs2, rs2_data, ex_valid, ex_result, wb_valid, wb_result);
  assign alu_b = dec.use_imm ? dec.imm : op_b;

  rv_alu alu0 (
    .op (dec.alu_op),
    .a  (op_a),
    .b  (alu_b),
    .y  (alu_y)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else if (advance) begin
      ex_valid <= dec_valid; // bubble when decode is empty
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      ex_result.rd    <= dec.rd;
      ex_result.value <= alu_y;
    end
  end

  // decode only lets known ops through, so the op field must be clean
  a_op_known: assert property (
    @(posedge clk) disable iff (reset)
    dec_valid |-> !$isunknown(dec.alu_op)
  ) else $error("unknown alu_op with dec_valid");

endmodule

// File: rtl/rv_decode_stage.sv
// input side of the execution pipeline
// accepts instruction words, decodes R/I-type ALU ops and registers them

`timescale 1ns/100ps

module rv_decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  input  rv_pkg::word_t     in_inst,
  input  logic              advance,
  output logic              in_ready,
  output logic              dec_valid,
  output rv_pkg::decoded_t  dec
);

  rv_pkg::inst_u    inst;
  rv_pkg::decoded_t nxt;
  logic             f3_ok;
  logic             supported;

  assign in_ready = advance; // whole pipe moves together
  assign inst     = in_inst;

  always_comb begin
    nxt         = '0;
    nxt.rd      = inst.r.rd;
    nxt.rs1     = inst.r.rs1;
    nxt.rs2     = inst.r.rs2;
    nxt.imm     = {{20{inst.i.imm[11]}}, inst.i.imm};
    nxt.alu_op  = rv_pkg::ALU_ADD;
    nxt.use_imm = 1'b0;
    supported   = 1'b0;
    f3_ok       = 1'b1;

    // funct3 picks the op for both formats
    case (inst.r.funct3)
      rv_pkg::F3_ADD_SUB: nxt.alu_op = rv_pkg::ALU_ADD;
      rv_pkg::F3_SLL:     nxt.alu_op = rv_pkg::ALU_SLL;
      rv_pkg::F3_XOR:     nxt.alu_op = rv_pkg::ALU_XOR;
      rv_pkg::F3_SRL:     nxt.alu_op = rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:      nxt.alu_op = rv_pkg::ALU_OR;
      rv_pkg::F3_AND:     nxt.alu_op = rv_pkg::ALU_AND;
      default:            f3_ok = 1'b0; // slt, sltu
    endcase

    case (inst.r.opcode)
      rv_pkg::OP_REG: begin
        if (inst.r.funct7 == rv_pkg::F7_ALT && inst.r.funct3 == rv_pkg::F3_ADD_SUB) begin
          nxt.alu_op = rv_pkg::ALU_SUB;
          supported  = 1'b1;
        end else begin
          supported = f3_ok && (inst.r.funct7 == rv_pkg::F7_BASE);
        end
      end
      rv_pkg::OP_IMM: begin
        nxt.use_imm = 1'b1;
        nxt.rs2     = '0;   // no second register source
        if (inst.i.funct3 == rv_pkg::F3_SLL || inst.i.funct3 == rv_pkg::F3_SRL) begin
          // upper imm bits act as funct7, srai is not kept
          supported = f3_ok && (inst.r.funct7 == rv_pkg::F7_BASE);
          nxt.imm   = {27'b0, inst.i.imm[4:0]};
        end else begin
          supported = f3_ok;
        end
      end
      default: supported = 1'b0; // dropped here without output
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else if (advance) begin
      dec_valid <= in_valid && supported;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      dec <= nxt;
    end
  end

endmodule

// File: rtl/rv_reg_file.sv
// architectural register file, 32 x 32-bit
// two combinational read ports, one write port, x0 never written

`timescale 1ns/100ps

module rv_reg_file (
  input  logic               clk,
  input  logic               reset,
  input  rv_pkg::reg_addr_t  rs1_addr,
  input  rv_pkg::reg_addr_t  rs2_addr,
  input  logic               wr_en,
  input  rv_pkg::reg_addr_t  wr_addr,
  input  rv_pkg::word_t      wr_data,
  output rv_pkg::word_t      rs1_data,
  output rv_pkg::word_t      rs2_data
);

  rv_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  // x0 must stay zero no matter what was written to it earlier
  a_x0_zero: assert property (
    @(posedge clk) disable iff (reset)
    ((rs1_addr == '0) |-> (rs1_data == '0)) and ((rs2_addr == '0) |-> (rs2_data == '0))
  ) else $error("x0 read returned nonzero");

endmodule

// File: rtl/rv_alu.sv
// combinational integer ALU for the kept RV32I operations
// shift amount comes from the low 5 bits of b

`timescale 1ns/100ps

module rv_alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD: begin
        y = a + b;
      end
      rv_pkg::ALU_SUB: begin
        y = a - b;
      end
      rv_pkg::ALU_SLL: begin
        y = a << shamt;
      end
      rv_pkg::ALU_XOR: begin
        y = a ^ b;
      end
      rv_pkg::ALU_SRL: begin
        y = a >> shamt; // logical, zero fill
      end
      rv_pkg::ALU_OR: begin
        y = a | b;
      end
      rv_pkg::ALU_AND: begin
        y = a & b;
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

// File: rtl/rv_pkg.sv
// shared types and encodings for the RV32I integer execution pipeline
// all modules refer to these by scoped name

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // major opcodes that survive decode
  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // sub

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_XOR,
    ALU_SRL,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_type_t;

  // one instruction word, viewed as either format
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } inst_u;

  typedef struct packed {
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    alu_op_e   alu_op;
    logic      use_imm;
    word_t     imm;     // already sign-extended
  } decoded_t;

  typedef struct packed {
    reg_addr_t rd;
    word_t     value;
  } result_t;

endpackage
